// File: mips_fetch_settings.svh
`ifndef MIPS_FETCH_SETTINGS_SVH
`define MIPS_FETCH_SETTINGS_SVH

//////////////////////////////
// Datapath sizes
//////////////////////////////

// Instruction word and PC width
`define MIPS_WORD_W 32

// Instruction memory depth in words
`define MIPS_ROM_WORDS 64

// Word address width into the instruction memory
`define MIPS_ROM_AW 6

//////////////////////////////
// Front end sizing
//////////////////////////////

// Entries in the fetch queue between memory and decoder
`define MIPS_QUEUE_DEPTH 4

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// File: mips_fetch_pkg.sv
package mips_fetch_pkg;

    //////////////////////////////
    // Instruction word layouts
    //////////////////////////////

    // Register format with rd, shift amount and function code
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    // Immediate format for loads, stores, branches and ALU immediates
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // Same 32 bits seen as either layout
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    //////////////////////////////
    // Primary opcodes
    //////////////////////////////

    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_LW      = 6'b100011;
    localparam logic [5:0] OPC_LB      = 6'b100000;
    localparam logic [5:0] OPC_SW      = 6'b101011;
    localparam logic [5:0] OPC_ADDI    = 6'b001000;
    localparam logic [5:0] OPC_ORI     = 6'b001101;
    localparam logic [5:0] OPC_SLTI    = 6'b001010;
    localparam logic [5:0] OPC_BEQ     = 6'b000100;
    localparam logic [5:0] OPC_J       = 6'b000010;

    // Function codes under the SPECIAL opcode
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    // Decoded operation handed to the execute stage
    typedef enum logic [4:0] {
        OP_LW, OP_LB, OP_SW, OP_ADD, OP_ADDI, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_ORI, OP_NOR, OP_XOR, OP_SLT, OP_SLTI,
        OP_BEQ, OP_SLL, OP_J, OP_ILLEGAL
    } mips_op_e;

endpackage

// File: pc_sequencer.sv
`include "mips_fetch_settings.svh"

module pc_sequencer
(
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     run,
    input  logic [$clog2(`MIPS_QUEUE_DEPTH + 1)-1:0] queue_count,
    input  logic                                     redirect,
    input  logic [`MIPS_WORD_W-1:0]                  redirect_pc,
    output logic                                     fetch_en,
    output logic [`MIPS_WORD_W-1:0]                  fetch_pc,
    output logic [`MIPS_WORD_W-1:0]                  inflight_pc,
    output logic                                     inflight_void
);

    localparam int CNT_W = $clog2(`MIPS_QUEUE_DEPTH + 1);

    // Current fetch address
    logic [`MIPS_WORD_W-1:0] pc;
    // One read outstanding in the memory pipe
    logic                    inflight;
    // Queue entries plus the read that has not pushed yet
    logic [CNT_W:0]          occupancy;
    logic                    room;

    //////////////////////////////
    // Issue throttle
    //////////////////////////////

    // Pops only free space so counting them is not needed
    assign occupancy = queue_count + inflight;
    assign room      = occupancy < `MIPS_QUEUE_DEPTH;

    assign fetch_en = run && room;
    assign fetch_pc = pc;

    //////////////////////////////
    // PC and in-flight tracking
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            pc            <= `MIPS_RESET_PC;
            inflight      <= 1'b0;
            inflight_void <= 1'b0;
        end
        else
        begin
            inflight <= fetch_en;
            // A read issued in the redirect cycle belongs to the old path
            inflight_void <= redirect && fetch_en;
            if (redirect)
            begin
                pc <= redirect_pc;
            end
            else if (fetch_en)
            begin
                // Sequential fetch, one word per issue
                pc <= pc + 'd4;
            end
        end
    end

    // PC copy lines up with the word out of the memory
    always_ff @(posedge clk)
    begin
        inflight_pc <= pc;
    end

endmodule

// File: instr_rom.sv
`include "mips_fetch_settings.svh"

module instr_rom
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    load_en,
    input  logic [`MIPS_ROM_AW-1:0] load_addr,
    input  logic [`MIPS_WORD_W-1:0] load_data,
    input  logic                    fetch_en,
    input  logic [`MIPS_WORD_W-1:0] fetch_pc,
    output logic                    rd_valid,
    output logic [`MIPS_WORD_W-1:0] rd_word
);

    // Word organized storage
    logic [`MIPS_WORD_W-1:0] mem [`MIPS_ROM_WORDS];
    // PC with the byte offset removed
    logic [`MIPS_ROM_AW-1:0] rd_addr;

    assign rd_addr = fetch_pc[`MIPS_ROM_AW+1:2];

    //////////////////////////////
    // Program load port
    //////////////////////////////

    // One word per cycle while the core is not running
    always_ff @(posedge clk)
    begin
        if (load_en)
        begin
            mem[load_addr] <= load_data;
        end
    end

    //////////////////////////////
    // Registered fetch read
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (fetch_en)
        begin
            rd_word <= mem[rd_addr];
        end
    end

    // Valid follows the request by one cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= fetch_en;
        end
    end

endmodule

// File: fetch_queue.sv
`include "mips_fetch_settings.svh"

module fetch_queue
(
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     push,
    input  mips_fetch_pkg::instr_u                   push_word,
    input  logic [`MIPS_WORD_W-1:0]                  push_pc,
    input  logic                                     flush,
    input  logic                                     pop,
    output mips_fetch_pkg::instr_u                   head_word,
    output logic [`MIPS_WORD_W-1:0]                  head_pc,
    output logic                                     not_empty,
    output logic [$clog2(`MIPS_QUEUE_DEPTH + 1)-1:0] count
);

    import mips_fetch_pkg::*;

    localparam int PTR_W = $clog2(`MIPS_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`MIPS_QUEUE_DEPTH + 1);

    // Word and PC stored side by side per entry
    instr_u                  word_mem [`MIPS_QUEUE_DEPTH];
    logic [`MIPS_WORD_W-1:0] pc_mem   [`MIPS_QUEUE_DEPTH];
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic                    empty;
    logic                    push_ok;
    logic                    pop_ok;

    //////////////////////////////
    // Head and status
    //////////////////////////////

    // Flush wins over any push in the same cycle
    assign push_ok = push && !flush;
    assign pop_ok  = pop && not_empty && !flush;
    assign empty   = (count == '0);

    // Empty queue passes the incoming word straight to the head
    assign head_word = empty ? push_word : word_mem[rd_ptr];
    assign head_pc   = empty ? push_pc : pc_mem[rd_ptr];
    assign not_empty = !empty || push_ok;

    //////////////////////////////
    // Storage
    //////////////////////////////

    // Written even on a bypass so the pointers stay in step
    always_ff @(posedge clk)
    begin
        if (push_ok)
        begin
            word_mem[wr_ptr] <= push_word;
            pc_mem[wr_ptr]   <= push_pc;
        end
    end

    // Pointers wrap at the last entry
    always_ff @(posedge clk)
    begin
        if (!rst_n || flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(`MIPS_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(`MIPS_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push_ok) - CNT_W'(pop_ok);
        end
    end

endmodule

// File: instr_decoder.sv
`include "mips_fetch_settings.svh"

module instr_decoder
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      not_empty,
    input  mips_fetch_pkg::instr_u    head_word,
    input  logic [`MIPS_WORD_W-1:0]   head_pc,
    input  logic                      stall,
    input  logic                      flush,
    output logic                      pop,
    output logic                      dec_valid,
    output logic [`MIPS_WORD_W-1:0]   dec_pc,
    output mips_fetch_pkg::mips_op_e  dec_op,
    output logic [4:0]                dec_rs,
    output logic [4:0]                dec_rt,
    output logic [4:0]                dec_rd,
    output logic [4:0]                dec_shamt,
    output logic [`MIPS_WORD_W-1:0]   dec_imm,
    output logic [`MIPS_WORD_W-1:0]   dec_target,
    output logic                      dec_illegal
);

    import mips_fetch_pkg::*;

    mips_op_e                op_next;
    logic [`MIPS_WORD_W-1:0] imm_next;
    logic [`MIPS_WORD_W-1:0] pc_plus4;
    logic [`MIPS_WORD_W-1:0] target_next;

    // Take the head whenever downstream is not holding us
    assign pop = not_empty && !stall;

    //////////////////////////////
    // Operation classify
    //////////////////////////////

    always_comb
    begin
        op_next = OP_ILLEGAL;
        if (head_word.i.opcode == OPC_SPECIAL)
        begin
            // Register ops are told apart by funct
            case (head_word.r.funct)
                FN_ADD:  op_next = OP_ADD;
                FN_SUB:  op_next = OP_SUB;
                FN_SUBU: op_next = OP_SUBU;
                FN_AND:  op_next = OP_AND;
                FN_OR:   op_next = OP_OR;
                FN_NOR:  op_next = OP_NOR;
                FN_XOR:  op_next = OP_XOR;
                FN_SLT:  op_next = OP_SLT;
                FN_SLL:  op_next = OP_SLL;
                default: op_next = OP_ILLEGAL;
            endcase
        end
        else
        begin
            case (head_word.i.opcode)
                OPC_LW:   op_next = OP_LW;
                OPC_LB:   op_next = OP_LB;
                OPC_SW:   op_next = OP_SW;
                OPC_ADDI: op_next = OP_ADDI;
                OPC_ORI:  op_next = OP_ORI;
                OPC_SLTI: op_next = OP_SLTI;
                OPC_BEQ:  op_next = OP_BEQ;
                OPC_J:    op_next = OP_J;
                default:  op_next = OP_ILLEGAL;
            endcase
        end
    end

    // ORI is the only zero extended immediate, all others sign extend
    assign imm_next = (head_word.i.opcode == OPC_ORI) ?
                      {{(`MIPS_WORD_W - 16){1'b0}}, head_word.i.imm} :
                      {{(`MIPS_WORD_W - 16){head_word.i.imm[15]}}, head_word.i.imm};

    // Jump target stays in the 256 MB region of the delay slot
    assign pc_plus4    = head_pc + 'd4;
    assign target_next = {pc_plus4[`MIPS_WORD_W-1:`MIPS_WORD_W-4], head_word[25:0], 2'b00};

    //////////////////////////////
    // Output registers
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n || flush)
        begin
            dec_valid <= 1'b0;
        end
        else if (pop)
        begin
            dec_valid <= 1'b1;
        end
        else if (!stall)
        begin
            // Current output consumed and nothing new behind it
            dec_valid <= 1'b0;
        end
    end

    // Fields only move on a pop so a stall holds them
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            dec_pc      <= head_pc;
            dec_op      <= op_next;
            dec_rs      <= head_word.i.rs;
            dec_rt      <= head_word.i.rt;
            dec_rd      <= head_word.r.rd;
            dec_shamt   <= head_word.r.shamt;
            dec_imm     <= imm_next;
            dec_target  <= target_next;
            dec_illegal <= (op_next == OP_ILLEGAL);
        end
    end

endmodule

// File: mips_fetch_top.sv
`include "mips_fetch_settings.svh"

module mips_fetch_top
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run,
    input  logic                      load_en,
    input  logic [`MIPS_ROM_AW-1:0]   load_addr,
    input  logic [`MIPS_WORD_W-1:0]   load_data,
    input  logic                      redirect,
    input  logic [`MIPS_WORD_W-1:0]   redirect_pc,
    input  logic                      stall,
    output logic                      dec_valid,
    output logic [`MIPS_WORD_W-1:0]   dec_pc,
    output mips_fetch_pkg::mips_op_e  dec_op,
    output logic [4:0]                dec_rs,
    output logic [4:0]                dec_rt,
    output logic [4:0]                dec_rd,
    output logic [4:0]                dec_shamt,
    output logic [`MIPS_WORD_W-1:0]   dec_imm,
    output logic [`MIPS_WORD_W-1:0]   dec_target,
    output logic                      dec_illegal
);

    import mips_fetch_pkg::*;

    localparam int CNT_W = $clog2(`MIPS_QUEUE_DEPTH + 1);

    // Sequencer to memory
    logic                    fetch_en;
    logic [`MIPS_WORD_W-1:0] fetch_pc;
    logic [`MIPS_WORD_W-1:0] inflight_pc;
    logic                    inflight_void;
    // Memory to queue
    logic                    rd_valid;
    logic [`MIPS_WORD_W-1:0] rd_word;
    logic                    push;
    // Queue to decoder
    instr_u                  head_word;
    logic [`MIPS_WORD_W-1:0] head_pc;
    logic                    not_empty;
    logic                    pop;
    logic [CNT_W-1:0]        queue_count;

    // Old path read is dropped after a redirect
    assign push = rd_valid && !inflight_void;

    pc_sequencer u_pc_sequencer
    (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .queue_count   (queue_count),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .fetch_en      (fetch_en),
        .fetch_pc      (fetch_pc),
        .inflight_pc   (inflight_pc),
        .inflight_void (inflight_void)
    );

    instr_rom u_instr_rom
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .fetch_en  (fetch_en),
        .fetch_pc  (fetch_pc),
        .rd_valid  (rd_valid),
        .rd_word   (rd_word)
    );

    // Redirect doubles as the flush of queue and decoder
    fetch_queue u_fetch_queue
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_word (rd_word),
        .push_pc   (inflight_pc),
        .flush     (redirect),
        .pop       (pop),
        .head_word (head_word),
        .head_pc   (head_pc),
        .not_empty (not_empty),
        .count     (queue_count)
    );

    instr_decoder u_instr_decoder
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .not_empty   (not_empty),
        .head_word   (head_word),
        .head_pc     (head_pc),
        .stall       (stall),
        .flush       (redirect),
        .pop         (pop),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_op      (dec_op),
        .dec_rs      (dec_rs),
        .dec_rt      (dec_rt),
        .dec_rd      (dec_rd),
        .dec_shamt   (dec_shamt),
        .dec_imm     (dec_imm),
        .dec_target  (dec_target),
        .dec_illegal (dec_illegal)
    );

endmodule

// File: mips_fetch_sva.sv
`include "mips_fetch_settings.svh"

module mips_fetch_sva
(
    input logic                                     clk,
    input logic                                     rst_n,
    input logic                                     push,
    input logic                                     flush,
    input logic                                     pop,
    input logic                                     not_empty,
    input logic [$clog2(`MIPS_QUEUE_DEPTH + 1)-1:0] count
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // Sequencer throttle keeps pushes away from a full queue
    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && !flush && count == `MIPS_QUEUE_DEPTH))
    else
    begin
        fail_count++;
        $error("push into a full fetch queue");
    end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> not_empty)
    else
    begin
        fail_count++;
        $error("pop from an empty fetch queue");
    end

    // Flush empties the queue in one cycle and the voided read never pushes
    empty_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> (count == '0 && !push))
    else
    begin
        fail_count++;
        $error("fetch queue not empty after flush");
    end

endmodule

bind fetch_queue mips_fetch_sva sva_i
(
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .flush     (flush),
    .pop       (pop),
    .not_empty (not_empty),
    .count     (count)
);

// File: mips_fetch_tb.sv
`include "mips_fetch_settings.svh"

module mips_fetch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import mips_fetch_pkg::*;

    // Per test budget in cycles, summed up for the watchdog
    localparam int SETUP_CYCLES = `MIPS_ROM_WORDS + 10;
    localparam int SEQ_LIMIT    = 60;
    localparam int ILL_LIMIT    = 120;
    localparam int BP_LIMIT     = 400;
    localparam int REDIR_LIMIT  = 40;
    localparam int IDLE_CYCLES  = 20;
    localparam int TOTAL_CYCLES = 5 * SETUP_CYCLES + SEQ_LIMIT + ILL_LIMIT + BP_LIMIT
                                + 2 * REDIR_LIMIT + 2 * IDLE_CYCLES;

    logic                    clk;
    logic                    rst_n;
    logic                    run;
    logic                    load_en;
    logic [`MIPS_ROM_AW-1:0] load_addr;
    logic [`MIPS_WORD_W-1:0] load_data;
    logic                    redirect;
    logic [`MIPS_WORD_W-1:0] redirect_pc;
    logic                    stall;
    logic                    dec_valid;
    logic [`MIPS_WORD_W-1:0] dec_pc;
    mips_op_e                dec_op;
    logic [4:0]              dec_rs;
    logic [4:0]              dec_rt;
    logic [4:0]              dec_rd;
    logic [4:0]              dec_shamt;
    logic [`MIPS_WORD_W-1:0] dec_imm;
    logic [`MIPS_WORD_W-1:0] dec_target;
    logic                    dec_illegal;

    // Mirror of the loaded program, indexed by word address
    logic [`MIPS_WORD_W-1:0] prog [`MIPS_ROM_WORDS];
    logic [31:0]             rng;
    string                   test_name;

    mips_fetch_top dut_i
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .stall       (stall),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_op      (dec_op),
        .dec_rs      (dec_rs),
        .dec_rt      (dec_rt),
        .dec_rd      (dec_rd),
        .dec_shamt   (dec_shamt),
        .dec_imm     (dec_imm),
        .dec_target  (dec_target),
        .dec_illegal (dec_illegal)
    );

    // 20 ns period
    always #10 clk = ~clk;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Opcode picks the operation, SPECIAL words go by funct
    function automatic mips_op_e ref_op(input logic [31:0] w);
        mips_op_e op;
        op = OP_ILLEGAL;
        if (w[31:26] == OPC_SPECIAL)
        begin
            case (w[5:0])
                FN_ADD:  op = OP_ADD;
                FN_SUB:  op = OP_SUB;
                FN_SUBU: op = OP_SUBU;
                FN_AND:  op = OP_AND;
                FN_OR:   op = OP_OR;
                FN_NOR:  op = OP_NOR;
                FN_XOR:  op = OP_XOR;
                FN_SLT:  op = OP_SLT;
                FN_SLL:  op = OP_SLL;
                default: op = OP_ILLEGAL;
            endcase
        end
        else
        begin
            case (w[31:26])
                OPC_LW:   op = OP_LW;
                OPC_LB:   op = OP_LB;
                OPC_SW:   op = OP_SW;
                OPC_ADDI: op = OP_ADDI;
                OPC_ORI:  op = OP_ORI;
                OPC_SLTI: op = OP_SLTI;
                OPC_BEQ:  op = OP_BEQ;
                OPC_J:    op = OP_J;
                default:  op = OP_ILLEGAL;
            endcase
        end
        return op;
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic fail_stop(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic compare_op(input string what, input mips_op_e exp, input mips_op_e act);
        if (exp !== act)
        begin
            fail_stop($sformatf("Error: %s %s expected %s actual %s",
                                test_name, what, exp.name(), act.name()));
        end
    endtask

    task automatic compare_word(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        if (exp !== act)
        begin
            fail_stop($sformatf("Error: %s %s expected %h actual %h", test_name, what, exp, act));
        end
    endtask

    task automatic compare_field(input string what, input logic [4:0] exp,
                                 input logic [4:0] act);
        if (exp !== act)
        begin
            fail_stop($sformatf("Error: %s %s expected %h actual %h", test_name, what, exp, act));
        end
    endtask

    task automatic compare_flag(input string what, input logic exp, input logic act);
        if (exp !== act)
        begin
            fail_stop($sformatf("Error: %s %s expected %b actual %b", test_name, what, exp, act));
        end
    endtask

    // Whole decoded output against the word the model holds at that PC
    task automatic check_output(input logic [31:0] exp_pc);
        logic [31:0] w;
        logic [31:0] pc4;
        logic [31:0] imm;
        mips_op_e    op;
        w   = prog[exp_pc[`MIPS_ROM_AW+1:2]];
        pc4 = exp_pc + 32'd4;
        op  = ref_op(w);
        // Zero extension only for ORI
        imm = (w[31:26] == OPC_ORI) ? {16'h0000, w[15:0]} : {{16{w[15]}}, w[15:0]};
        compare_word("pc", exp_pc, dec_pc);
        compare_op("op", op, dec_op);
        compare_field("rs", w[25:21], dec_rs);
        compare_field("rt", w[20:16], dec_rt);
        compare_field("rd", w[15:11], dec_rd);
        compare_field("shamt", w[10:6], dec_shamt);
        compare_word("imm", imm, dec_imm);
        compare_word("target", {pc4[31:28], w[25:0], 2'b00}, dec_target);
        compare_flag("illegal", op == OP_ILLEGAL, dec_illegal);
    endtask

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Load port only while the core is stopped
    task automatic load_program();
        run      = 1'b0;
        stall    = 1'b0;
        redirect = 1'b0;
        for (int a = 0; a < `MIPS_ROM_WORDS; a++)
        begin
            load_en   = 1'b1;
            load_addr = a[`MIPS_ROM_AW-1:0];
            load_data = prog[a];
            @(negedge clk);
        end
        load_en = 1'b0;
    endtask

    task automatic reset_dut();
        run   = 1'b0;
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic fill_random();
        for (int a = 0; a < `MIPS_ROM_WORDS; a++)
        begin
            rng     = lcg_next(rng);
            prog[a] = rng;
        end
    endtask

    // Output taken when valid and not stalled, PCs must follow program order
    task automatic run_stream(input int n_words, input int limit, input int stall_pct,
                              input logic [31:0] start_pc);
        int          got;
        int          cycles;
        logic [31:0] exp_pc;
        got    = 0;
        cycles = 0;
        exp_pc = start_pc;
        run    = 1'b1;
        while (got < n_words)
        begin
            @(negedge clk);
            rng   = lcg_next(rng);
            stall = (int'(rng[31:16]) % 100) < stall_pct;
            if (dec_valid && !stall)
            begin
                check_output(exp_pc);
                exp_pc = exp_pc + 32'd4;
                got++;
            end
            cycles++;
            if (cycles > limit)
            begin
                fail_stop($sformatf("Timeout: test %s decoded only %0d of %0d words",
                                    test_name, got, n_words));
            end
        end
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic seq_decode_test();
        logic [5:0] opcs [8];
        logic [5:0] fns  [9];
        opcs = '{OPC_LW, OPC_LB, OPC_SW, OPC_ADDI, OPC_ORI, OPC_SLTI, OPC_BEQ, OPC_J};
        fns  = '{FN_ADD, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_NOR, FN_XOR, FN_SLT, FN_SLL};
        test_name = "seq_decode";
        for (int a = 0; a < `MIPS_ROM_WORDS; a++)
        begin
            prog[a] = '0;
        end
        // Random register fields, immediate sign bit set so zero and sign extension differ
        for (int k = 0; k < 8; k++)
        begin
            rng     = lcg_next(rng);
            prog[k] = {opcs[k], rng[25:16], 1'b1, rng[14:0]};
        end
        for (int k = 0; k < 9; k++)
        begin
            rng         = lcg_next(rng);
            prog[8 + k] = {OPC_SPECIAL, rng[25:6], fns[k]};
        end
        load_program();
        reset_dut();
        run_stream(17, SEQ_LIMIT, 0, `MIPS_RESET_PC);
    endtask

    task automatic illegal_word_test();
        test_name = "illegal_word";
        fill_random();
        load_program();
        reset_dut();
        run_stream(`MIPS_ROM_WORDS, ILL_LIMIT, 0, `MIPS_RESET_PC);
    endtask

    task automatic back_pressure_test();
        test_name = "back_pressure";
        fill_random();
        load_program();
        reset_dut();
        run_stream(`MIPS_ROM_WORDS, BP_LIMIT, 40, `MIPS_RESET_PC);
    endtask

    task automatic redirect_test();
        logic [31:0] target;
        test_name = "redirect";
        fill_random();
        load_program();
        reset_dut();
        run_stream(6, REDIR_LIMIT, 0, `MIPS_RESET_PC);
        rng    = lcg_next(rng);
        target = 32'(rng[`MIPS_ROM_AW+1:2]) << 2;
        // One cycle pulse, the stream restarts at the target
        redirect    = 1'b1;
        redirect_pc = target;
        @(negedge clk);
        redirect = 1'b0;
        run_stream(8, REDIR_LIMIT, 0, target);
    endtask

    task automatic reset_idle_test();
        test_name = "reset_idle";
        fill_random();
        load_program();
        reset_dut();
        repeat (IDLE_CYCLES)
        begin
            @(negedge clk);
            compare_flag("dec_valid while idle", 1'b0, dec_valid);
        end
        run_stream(4, IDLE_CYCLES, 0, `MIPS_RESET_PC);
    endtask

    //////////////////////////////
    // Run control
    //////////////////////////////

    initial
    begin
        #(TOTAL_CYCLES * 20 * 4);
        fail_stop("Watchdog expired before the tests completed");
    end

    // Bound queue assertions raise their count on a failure
    initial
    begin
        wait (dut_i.u_fetch_queue.sva_i.fail_count != 0);
        fail_stop("Concurrent assertions in the fetch queue failed");
    end

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        run         = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        stall       = 1'b0;
        rng         = 32'h1992759a;
        @(negedge clk);
        seq_decode_test();
        illegal_word_test();
        back_pressure_test();
        redirect_test();
        reset_idle_test();
        // Bound assertions count their own failures
        if (dut_i.u_fetch_queue.sva_i.fail_count == 0)
        begin
            $display("TESTS PASSED");
            $finish;
        end
        else
        begin
            fail_stop("Concurrent assertions in the fetch queue failed");
        end
    end

endmodule

// File: mips_fetch.f
+incdir+.
mips_fetch_pkg.sv
pc_sequencer.sv
instr_rom.sv
fetch_queue.sv
instr_decoder.sv
mips_fetch_top.sv
mips_fetch_sva.sv
mips_fetch_tb.sv
